// ==== aes_cipher_ctrl.sv ====
// Top level of the AES cipher control sequencer, instantiated by the cipher core
`timescale 1ns/1ps

module aes_cipher_ctrl import aes_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  cmd_t      cmd_i,
  input  cfg_t      cfg_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  input  logic      key_expand_out_req_i,
  input  logic      sub_bytes_out_req_i,
  input  err_t      err_i,
  output logic      alert_o,
  output rnd_ctr_t  rnd_ctr_o,
  output dp_ctrl_t  dp_ctrl_o,
  output key_ctrl_t key_ctrl_o
);

  cmd_t           cmd_q;
  round_phase_e   phase;
  key_words_sel_e key_words_sel;
  round_key_sel_e round_key_sel;
  logic           cmd_load, crypt_clr, dkg_clr, clears_clr;
  logic           rnd_start, rnd_step, cyc_clr;
  logic           last_round, sbox_done;

  aes_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .in_valid_i, .cmd_i, .cfg_i, .out_ready_i,
    .key_expand_out_req_i, .sub_bytes_out_req_i, .err_i,
    .cmd_q_i         (cmd_q),
    .rnd_ctr_i       (rnd_ctr_o),
    .last_round_i    (last_round),
    .sbox_done_i     (sbox_done),
    .key_words_sel_i (key_words_sel),
    .round_key_sel_i (round_key_sel),
    .in_ready_o, .out_valid_o, .alert_o, .dp_ctrl_o, .key_ctrl_o,
    .phase_o         (phase),
    .cmd_load_o      (cmd_load),
    .crypt_clr_o     (crypt_clr),
    .dkg_clr_o       (dkg_clr),
    .clears_clr_o    (clears_clr),
    .rnd_start_o     (rnd_start),
    .rnd_step_o      (rnd_step),
    .cyc_clr_o       (cyc_clr)
  );

  aes_cmd_regs u_cmd_regs (
    .clk_i, .rst_ni, .cmd_i,
    .load_i       (cmd_load),
    .crypt_clr_i  (crypt_clr),
    .dkg_clr_i    (dkg_clr),
    .clears_clr_i (clears_clr),
    .cmd_q_o      (cmd_q)
  );

  // Key length is stable from input to output handshake
  aes_round_timer u_round_timer (
    .clk_i, .rst_ni,
    .key_len_i    (cfg_i.key_len),
    .start_i      (rnd_start),
    .step_i       (rnd_step),
    .cyc_clr_i    (cyc_clr),
    .rnd_ctr_o,
    .last_round_o (last_round),
    .sbox_done_o  (sbox_done)
  );

  aes_key_words_sel u_key_words_sel (
    .phase_i         (phase),
    .cfg_i,
    .dec_key_gen_i   (cmd_q.dec_key_gen),
    .key_words_sel_o (key_words_sel),
    .round_key_sel_o (round_key_sel)
  );

endmodule

// ==== aes_cipher_ctrl_props.sv ====
// Concurrent checks on handshakes and the fatal alert, bound into every sequencer instance
`timescale 1ns/1ps

module aes_cipher_ctrl_props import aes_ctrl_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      in_ready_o,
  input logic      out_valid_o,
  input logic      alert_o,
  input dp_ctrl_t  dp_ctrl_o,
  input key_ctrl_t key_ctrl_o
);

  logic any_we;

  // Any write into the state or key registers
  assign any_we = dp_ctrl_o.state_we | key_ctrl_o.key_full_we | key_ctrl_o.key_dec_we;

  // Alert is sticky until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni) alert_o |=> alert_o)
    else $error("alert_o dropped without a reset");

  // Input and output sides never open together
  no_both_handshakes: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                       !(in_ready_o && out_valid_o))
    else $error("in_ready_o and out_valid_o high together");

  // Error state leaves all registers untouched
  alert_no_writes: assert property (@(posedge clk_i) disable iff (!rst_ni) alert_o |-> !any_we)
    else $error("Write enable active while alert_o is high");

endmodule

bind aes_cipher_ctrl aes_cipher_ctrl_props u_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .alert_o     (alert_o),
  .dp_ctrl_o   (dp_ctrl_o),
  .key_ctrl_o  (key_ctrl_o)
);

// ==== aes_cmd_regs.sv ====
// Command register of the AES sequencer, loaded at the input handshake and cleared at completion
`timescale 1ns/1ps

module aes_cmd_regs import aes_ctrl_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  cmd_t cmd_i,
  input  logic load_i,
  input  logic crypt_clr_i,
  input  logic dkg_clr_i,
  input  logic clears_clr_i,
  output cmd_t cmd_q_o
);

  cmd_t cmd_load;
  cmd_t cmd_q;

  // Clears take priority over crypto commands
  // Key generation overrides encrypt/decrypt
  always_comb begin
    cmd_load = cmd_i;
    if (cmd_i.key_clear || cmd_i.data_out_clear) begin
      cmd_load.crypt       = 1'b0;
      cmd_load.dec_key_gen = 1'b0;
    end else begin
      cmd_load.crypt = cmd_i.crypt & ~cmd_i.dec_key_gen;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '0;
    end else if (load_i) begin
      cmd_q <= cmd_load;
    end else begin
      // Individual bits drop as their operation completes
      if (crypt_clr_i) begin
        cmd_q.crypt <= 1'b0;
      end
      if (dkg_clr_i) begin
        cmd_q.dec_key_gen <= 1'b0;
      end
      if (clears_clr_i) begin
        cmd_q.key_clear      <= 1'b0;
        cmd_q.data_out_clear <= 1'b0;
      end
    end
  end

  assign cmd_q_o = cmd_q;

endmodule

// ==== aes_ctrl_fsm.sv ====
// Sequencing FSM of the AES cipher core, driving handshakes, counters and data-path strobes
`timescale 1ns/1ps

module aes_ctrl_fsm import aes_ctrl_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           in_valid_i,
  input  cmd_t           cmd_i,
  input  cfg_t           cfg_i,
  input  logic           out_ready_i,
  input  logic           key_expand_out_req_i,
  input  logic           sub_bytes_out_req_i,
  input  err_t           err_i,
  input  cmd_t           cmd_q_i,
  input  rnd_ctr_t       rnd_ctr_i,
  input  logic           last_round_i,
  input  logic           sbox_done_i,
  input  key_words_sel_e key_words_sel_i,
  input  round_key_sel_e round_key_sel_i,
  output logic           in_ready_o,
  output logic           out_valid_o,
  output logic           alert_o,
  output dp_ctrl_t       dp_ctrl_o,
  output key_ctrl_t      key_ctrl_o,
  output round_phase_e   phase_o,
  output logic           cmd_load_o,
  output logic           crypt_clr_o,
  output logic           dkg_clr_o,
  output logic           clears_clr_o,
  output logic           rnd_start_o,
  output logic           rnd_step_o,
  output logic           cyc_clr_o
);

  ctrl_state_e state_d, state_q;
  logic        advance;
  logic        out_err;
  logic        rnd_ctr_bad;

  // Faults that must keep data from being released
  assign out_err = err_i.mux_sel | err_i.sp_enc | err_i.op;

  // Round counter must match the state
  always_comb begin
    case (state_q)
      INIT:          rnd_ctr_bad = (rnd_ctr_i != '0);
      ROUND, FINISH: rnd_ctr_bad = (rnd_ctr_i == '0);
      default:       rnd_ctr_bad = 1'b0;
    endcase
  end

  ////////////////////
  // Next state and strobes
  ////////////////////

  always_comb begin
    in_ready_o   = 1'b0;
    out_valid_o  = 1'b0;
    alert_o      = 1'b0;
    phase_o      = PH_NONE;
    cmd_load_o   = 1'b0;
    crypt_clr_o  = 1'b0;
    dkg_clr_o    = 1'b0;
    clears_clr_o = 1'b0;
    rnd_start_o  = 1'b0;
    rnd_step_o   = 1'b0;
    cyc_clr_o    = 1'b0;
    advance      = 1'b0;
    state_d      = state_q;

    // Cipher data path idles
    dp_ctrl_o.state_sel         = STATE_ROUND;
    dp_ctrl_o.state_we          = 1'b0;
    dp_ctrl_o.add_rk_sel        = ADD_RK_ROUND;
    dp_ctrl_o.sub_bytes_en      = 1'b0;
    dp_ctrl_o.sub_bytes_out_ack = 1'b0;

    // Key data path idles, word selection follows the phase
    key_ctrl_o.key_full_sel       = KEY_FULL_ROUND;
    key_ctrl_o.key_full_we        = 1'b0;
    key_ctrl_o.key_dec_sel        = KEY_DEC_EXPAND;
    key_ctrl_o.key_dec_we         = 1'b0;
    key_ctrl_o.key_expand_en      = 1'b0;
    key_ctrl_o.key_expand_out_ack = 1'b0;
    key_ctrl_o.key_expand_clear   = 1'b0;
    key_ctrl_o.key_words_sel      = key_words_sel_i;
    key_ctrl_o.round_key_sel      = round_key_sel_i;

    case (state_q)
      IDLE: begin
        in_ready_o = 1'b1;
        cyc_clr_o  = 1'b1;
        if (in_valid_i) begin
          if (cmd_i.key_clear || cmd_i.data_out_clear) begin
            cmd_load_o = 1'b1;
            // State goes first when the data output is wiped
            state_d = cmd_i.data_out_clear ? CLEAR_S : CLEAR_KD;
          end else if (cmd_i.crypt || cmd_i.dec_key_gen) begin
            cmd_load_o = 1'b1;
            // Load input block, or clear it for key generation
            dp_ctrl_o.state_sel = cmd_i.dec_key_gen ? STATE_CLEAR : STATE_INIT;
            dp_ctrl_o.state_we  = 1'b1;
            // Restart expansion from the full key
            key_ctrl_o.key_expand_clear = 1'b1;
            key_ctrl_o.key_full_sel = (cmd_i.dec_key_gen || cfg_i.op == CIPH_FWD) ?
                                      KEY_FULL_ENC_INIT : KEY_FULL_DEC_INIT;
            key_ctrl_o.key_full_we  = 1'b1;
            rnd_start_o = 1'b1;
            state_d     = INIT;
          end else begin
            // Handshake without any command bit
            state_d = ERROR;
          end
        end
      end

      INIT: begin
        phase_o              = PH_INIT;
        dp_ctrl_o.add_rk_sel = ADD_RK_INIT;
        if (cfg_i.key_len != AES_256) begin
          // Wait for the first expanded key
          advance                  = key_expand_out_req_i & sbox_done_i;
          key_ctrl_o.key_expand_en = 1'b1;
          if (advance) begin
            key_ctrl_o.key_expand_out_ack = 1'b1;
            key_ctrl_o.key_full_we        = 1'b1;
            dp_ctrl_o.state_we            = cmd_q_i.crypt;
            rnd_step_o                    = 1'b1;
            state_d                       = ROUND;
          end
        end else begin
          // AES-256 holds two round keys from the start
          dp_ctrl_o.state_we = cmd_q_i.crypt;
          rnd_step_o         = 1'b1;
          state_d            = ROUND;
        end
      end

      ROUND: begin
        phase_o = PH_ROUND;
        // SubBytes result only matters when a block is processed
        advance = key_expand_out_req_i & sbox_done_i &
                  (cmd_q_i.dec_key_gen | sub_bytes_out_req_i);
        dp_ctrl_o.sub_bytes_en   = cmd_q_i.crypt;
        key_ctrl_o.key_expand_en = 1'b1;
        if (advance) begin
          dp_ctrl_o.sub_bytes_out_ack   = cmd_q_i.crypt;
          dp_ctrl_o.state_we            = cmd_q_i.crypt;
          key_ctrl_o.key_expand_out_ack = 1'b1;
          key_ctrl_o.key_full_we        = 1'b1;
          rnd_step_o                    = 1'b1;
          if (last_round_i) begin
            state_d = FINISH;
            if (cmd_q_i.dec_key_gen) begin
              // Decryption key is complete, try the handshake early
              key_ctrl_o.key_dec_we = 1'b1;
              out_valid_o           = 1'b1;
              if (out_ready_i) begin
                dkg_clr_o = 1'b1;
                state_d   = IDLE;
              end
            end
          end
        end
      end

      FINISH: begin
        phase_o              = PH_FINISH;
        dp_ctrl_o.add_rk_sel = ADD_RK_FINAL;
        // State is wiped on the way out
        dp_ctrl_o.state_sel    = STATE_CLEAR;
        dp_ctrl_o.sub_bytes_en = cmd_q_i.crypt;
        advance     = (sub_bytes_out_req_i & sbox_done_i) | cmd_q_i.dec_key_gen;
        // Withhold output on any selector or encoding fault
        out_valid_o = advance & ~out_err;
        if (out_valid_o && out_ready_i) begin
          dp_ctrl_o.sub_bytes_out_ack = cmd_q_i.crypt;
          dp_ctrl_o.state_we          = 1'b1;
          crypt_clr_o = 1'b1;
          dkg_clr_o   = 1'b1;
          cyc_clr_o   = 1'b1;
          state_d     = IDLE;
        end
      end

      CLEAR_S: begin
        dp_ctrl_o.state_sel = STATE_CLEAR;
        dp_ctrl_o.state_we  = 1'b1;
        state_d             = CLEAR_KD;
      end

      CLEAR_KD: begin
        if (cmd_q_i.key_clear) begin
          key_ctrl_o.key_full_sel = KEY_FULL_CLEAR;
          key_ctrl_o.key_full_we  = 1'b1;
          key_ctrl_o.key_dec_sel  = KEY_DEC_CLEAR;
          key_ctrl_o.key_dec_we   = 1'b1;
        end
        if (cmd_q_i.data_out_clear) begin
          // Pass the cleared state to the output with a zero key
          dp_ctrl_o.add_rk_sel = ADD_RK_INIT;
        end
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          clears_clr_o = 1'b1;
          state_d      = IDLE;
        end
      end

      ERROR: begin
        // Terminal, only reset leaves
        alert_o = 1'b1;
      end

      default: begin
        alert_o = 1'b1;
        state_d = ERROR;
      end
    endcase

    // Any reported fault ends in the error state
    if ((|err_i) || rnd_ctr_bad) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== aes_ctrl_pkg.sv ====
// Shared widths, round constants, encodings and strobe bundles of the AES cipher sequencer
package aes_ctrl_pkg;

  ////////////////////
  // Widths and constants
  ////////////////////

  // Round counter and round count width
  localparam int unsigned RndCtrW = 4;

  typedef logic [RndCtrW-1:0] rnd_ctr_t;

  // Total rounds per key length
  localparam rnd_ctr_t NumRounds128 = 4'd10;
  localparam rnd_ctr_t NumRounds192 = 4'd12;
  localparam rnd_ctr_t NumRounds256 = 4'd14;

  // Minimum S-box latency in cycles per round step
  localparam int unsigned SboxCycles = 5;
  localparam int unsigned CycCtrW    = 3;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic {CIPH_FWD, CIPH_INV} ciph_op_e;

  typedef enum logic [1:0] {AES_128, AES_192, AES_256} key_len_e;

  typedef enum logic [2:0] {
    IDLE, INIT, ROUND, FINISH, CLEAR_S, CLEAR_KD, ERROR
  } ctrl_state_e;

  // Round phase seen by the key word selector
  typedef enum logic [1:0] {PH_NONE, PH_INIT, PH_ROUND, PH_FINISH} round_phase_e;

  // Cipher data path selects
  typedef enum logic [1:0] {STATE_ROUND, STATE_INIT, STATE_CLEAR} state_sel_e;
  typedef enum logic [1:0] {ADD_RK_ROUND, ADD_RK_INIT, ADD_RK_FINAL} add_rk_sel_e;

  // Key data path selects
  typedef enum logic [1:0] {
    KEY_FULL_ROUND, KEY_FULL_ENC_INIT, KEY_FULL_DEC_INIT, KEY_FULL_CLEAR
  } key_full_sel_e;
  typedef enum logic {KEY_DEC_EXPAND, KEY_DEC_CLEAR} key_dec_sel_e;
  typedef enum logic [1:0] {
    KEY_WORDS_0123, KEY_WORDS_2345, KEY_WORDS_4567, KEY_WORDS_ZERO
  } key_words_sel_e;
  typedef enum logic {ROUND_KEY_DIRECT, ROUND_KEY_MIXED} round_key_sel_e;

  ////////////////////
  // Bundles
  ////////////////////

  // Command bits of one input handshake
  typedef struct packed {
    logic crypt;
    logic dec_key_gen;
    logic key_clear;
    logic data_out_clear;
  } cmd_t;

  // Configuration, stable for a whole operation
  typedef struct packed {
    ciph_op_e op;
    key_len_e key_len;
  } cfg_t;

  // Fault reports from the surrounding core
  typedef struct packed {
    logic mux_sel;
    logic sp_enc;
    logic rnd_ctr;
    logic op;
    logic alert_fatal;
  } err_t;

  // Cipher data path strobes
  typedef struct packed {
    state_sel_e  state_sel;
    logic        state_we;
    add_rk_sel_e add_rk_sel;
    logic        sub_bytes_en;
    logic        sub_bytes_out_ack;
  } dp_ctrl_t;

  // Key expansion data path strobes
  typedef struct packed {
    key_full_sel_e  key_full_sel;
    logic           key_full_we;
    key_dec_sel_e   key_dec_sel;
    logic           key_dec_we;
    logic           key_expand_en;
    logic           key_expand_out_ack;
    logic           key_expand_clear;
    key_words_sel_e key_words_sel;
    round_key_sel_e round_key_sel;
  } key_ctrl_t;

endpackage

// ==== aes_key_words_sel.sv ====
// Selection of key words and round-key form for the add-round-key step of each round phase
`timescale 1ns/1ps

module aes_key_words_sel import aes_ctrl_pkg::*; (
  input  round_phase_e   phase_i,
  input  cfg_t           cfg_i,
  input  logic           dec_key_gen_i,
  output key_words_sel_e key_words_sel_o,
  output round_key_sel_e round_key_sel_o
);

  logic lower_words;

  // Lower words for the initial round of forward and the later rounds of inverse
  assign lower_words = (phase_i == PH_INIT) ? (cfg_i.op == CIPH_FWD) :
                                              (cfg_i.op == CIPH_INV);

  always_comb begin
    key_words_sel_o = KEY_WORDS_ZERO;
    // No round key enters the state during key generation
    if (!dec_key_gen_i && (phase_i != PH_NONE)) begin
      case (cfg_i.key_len)
        AES_128: begin
          key_words_sel_o = KEY_WORDS_0123;
        end
        AES_192: begin
          key_words_sel_o = lower_words ? KEY_WORDS_0123 : KEY_WORDS_2345;
        end
        AES_256: begin
          key_words_sel_o = lower_words ? KEY_WORDS_0123 : KEY_WORDS_4567;
        end
        default: begin
          key_words_sel_o = KEY_WORDS_ZERO;
        end
      endcase
    end
  end

  // Equivalent inverse cipher mixes the round key in regular rounds only
  assign round_key_sel_o = ((phase_i == PH_ROUND) && (cfg_i.op == CIPH_INV)) ?
                           ROUND_KEY_MIXED : ROUND_KEY_DIRECT;

endmodule

// ==== aes_round_timer.sv ====
// Round counter, round count and S-box latency counter, stepped by the sequencer FSM
`timescale 1ns/1ps

module aes_round_timer import aes_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  key_len_e key_len_i,
  input  logic     start_i,
  input  logic     step_i,
  input  logic     cyc_clr_i,
  output rnd_ctr_t rnd_ctr_o,
  output logic     last_round_o,
  output logic     sbox_done_o
);

  rnd_ctr_t             rnd_ctr_q;
  rnd_ctr_t             num_rounds_d, num_rounds_q;
  rnd_ctr_t             num_rounds_regular;
  logic [CycCtrW-1:0]   cyc_ctr_q;

  // Round count per key length
  always_comb begin
    case (key_len_i)
      AES_128: num_rounds_d = NumRounds128;
      AES_192: num_rounds_d = NumRounds192;
      default: num_rounds_d = NumRounds256;
    endcase
  end

  ////////////////////
  // Round counter
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= '0;
    end else if (start_i) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= num_rounds_d;
    end else if (step_i) begin
      rnd_ctr_q <= rnd_ctr_q + rnd_ctr_t'(1);
    end
  end

  // Last regular round is one before the final round
  assign num_rounds_regular = num_rounds_q - rnd_ctr_t'(1);
  assign last_round_o       = (rnd_ctr_q >= num_rounds_regular);
  assign rnd_ctr_o          = rnd_ctr_q;

  ////////////////////
  // S-box cycle counter
  ////////////////////

  // Restarts with each step, then holds once the latency is covered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_ctr_q <= '0;
    end else if (start_i || step_i || cyc_clr_i) begin
      cyc_ctr_q <= '0;
    end else if (!sbox_done_o) begin
      cyc_ctr_q <= cyc_ctr_q + CycCtrW'(1);
    end
  end

  assign sbox_done_o = (cyc_ctr_q >= CycCtrW'(SboxCycles - 1));

endmodule

// ==== list.f ====
aes_ctrl_pkg.sv
aes_cmd_regs.sv
aes_round_timer.sv
aes_key_words_sel.sv
aes_ctrl_fsm.sv
aes_cipher_ctrl.sv
aes_cipher_ctrl_props.sv
tb_aes_cipher_ctrl.sv

// ==== tb_aes_cipher_ctrl.sv ====
// Directed testbench for the AES cipher sequencer, with the key-expansion and S-box units stubbed
`timescale 1ns/1ps

module tb_aes_cipher_ctrl import aes_ctrl_pkg::*;;

  logic      clk_i, rst_ni;
  logic      in_valid_i, in_ready_o;
  cmd_t      cmd_i;
  cfg_t      cfg_i;
  logic      out_valid_o, out_ready_i;
  logic      key_expand_out_req_i, sub_bytes_out_req_i;
  err_t      err_i;
  logic      alert_o;
  rnd_ctr_t  rnd_ctr_o;
  dp_ctrl_t  dp_ctrl_o;
  key_ctrl_t key_ctrl_o;
  integer    seed;

  aes_cipher_ctrl u_aes_cipher_ctrl (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Expected values
  ////////////////////

  function automatic rnd_ctr_t round_count(key_len_e kl);
    case (kl)
      AES_128: return NumRounds128;
      AES_192: return NumRounds192;
      default: return NumRounds256;
    endcase
  endfunction

  // Cycle of the first out_valid_o counted from the input handshake
  function automatic int crypt_latency(key_len_e kl);
    int init_cycles;
    init_cycles = (kl == AES_256) ? 1 : SboxCycles;
    return 1 + init_cycles + (int'(round_count(kl)) - 1) * SboxCycles + SboxCycles - 1;
  endfunction

  // Forward starts on the low words and inverse ends on them
  function automatic key_words_sel_e expected_words(logic init_phase, ciph_op_e op,
                                                    key_len_e kl);
    key_words_sel_e upper;
    upper = (kl == AES_192) ? KEY_WORDS_2345 : KEY_WORDS_4567;
    if (kl == AES_128) return KEY_WORDS_0123;
    if (init_phase) return (op == CIPH_FWD) ? KEY_WORDS_0123 : upper;
    return (op == CIPH_FWD) ? upper : KEY_WORDS_0123;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, act, exp));
  endtask

  task automatic check_rnd(string name, rnd_ctr_t act, rnd_ctr_t exp);
    if (act !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, act, exp));
  endtask

  task automatic check_cycle(string name, int act, int exp);
    if (act != exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, act, exp));
  endtask

  task automatic check_words(string name, key_words_sel_e act, key_words_sel_e exp);
    if (act !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %s, expected %s", $time, name,
                              act.name(), exp.name()));
  endtask

  task automatic check_sel(string name, state_sel_e act, state_sel_e exp);
    if (act !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %s, expected %s", $time, name,
                              act.name(), exp.name()));
  endtask

  task automatic check_full_sel(string name, key_full_sel_e act, key_full_sel_e exp);
    if (act !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %s, expected %s", $time, name,
                              act.name(), exp.name()));
  endtask

  task automatic check_dec_sel(string name, key_dec_sel_e act, key_dec_sel_e exp);
    if (act !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %s, expected %s", $time, name,
                              act.name(), exp.name()));
  endtask

  ////////////////////
  // Drivers and waits
  ////////////////////

  // Reset followed by the idle values of all outputs
  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("alert_o", alert_o, 1'b0);
    check_bit("state_we", dp_ctrl_o.state_we, 1'b0);
    check_rnd("rnd_ctr_o", rnd_ctr_o, '0);
  endtask

  // Handshake in cycle 0 and return at the middle of cycle 1
  task automatic send_cmd(cmd_t c, cfg_t g);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    cmd_i      <= c;
    cfg_i      <= g;
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    cmd_i      <= '0;
    @(negedge clk_i);
  endtask

  task automatic wait_out_valid(input int start, output int cyc);
    cyc = start;
    while (!out_valid_o) begin
      if (cyc > 200) stop_on_error("Timeout: out_valid_o did not rise within 200 cycles");
      @(negedge clk_i);
      cyc++;
    end
  endtask

  // Error state holds alert and blocks new commands
  task automatic check_error_held(int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit("alert_o", alert_o, 1'b1);
      check_bit("in_ready_o", in_ready_o, 1'b0);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_crypt(ciph_op_e op, key_len_e kl);
    cmd_t c;
    cfg_t g;
    int   cyc;
    c       = '0;
    c.crypt = 1'b1;
    g       = '{op: op, key_len: kl};
    send_cmd(c, g);
    check_words("key_words_sel in INIT", key_ctrl_o.key_words_sel, expected_words(1'b1, op, kl));
    wait_out_valid(1, cyc);
    check_cycle("out_valid_o cycle", cyc, crypt_latency(kl));
    check_rnd("rnd_ctr_o", rnd_ctr_o, round_count(kl));
    check_words("key_words_sel in FINISH", key_ctrl_o.key_words_sel,
                expected_words(1'b0, op, kl));
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    check_bit("out_valid_o", out_valid_o, 1'b0);
  endtask

  task automatic test_dec_key_gen(key_len_e kl);
    cmd_t c;
    cfg_t g;
    int   cyc;
    int   pulses;
    c             = '0;
    c.dec_key_gen = 1'b1;
    g             = '{op: CIPH_INV, key_len: kl};
    send_cmd(c, g);
    cyc    = 1;
    pulses = 0;
    while (1'b1) begin
      check_bit("state_we", dp_ctrl_o.state_we, 1'b0);
      check_bit("sub_bytes_en", dp_ctrl_o.sub_bytes_en, 1'b0);
      if (key_ctrl_o.key_dec_we) pulses++;
      if (out_valid_o) break;
      if (cyc > 200) stop_on_error("Timeout: key generation never raised out_valid_o");
      @(negedge clk_i);
      cyc++;
    end
    // Output comes with the last round advance, one step before FINISH
    check_cycle("key gen out_valid_o cycle", cyc, crypt_latency(kl) - SboxCycles);
    @(negedge clk_i);
    check_bit("key_dec_we", key_ctrl_o.key_dec_we, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    check_cycle("key_dec_we pulses", pulses, 1);
  endtask

  task automatic test_back_pressure();
    cmd_t     c;
    cfg_t     g;
    int       cyc;
    int       stall;
    g.key_len = key_len_e'($unsigned($random(seed)) % 3);
    g.op      = ciph_op_e'($unsigned($random(seed)) % 2);
    stall     = 1 + $unsigned($random(seed)) % 8;
    c         = '0;
    c.crypt   = 1'b1;
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    send_cmd(c, g);
    wait_out_valid(1, cyc);
    check_cycle("out_valid_o cycle", cyc, crypt_latency(g.key_len));
    repeat (stall) begin
      @(negedge clk_i);
      check_bit("out_valid_o", out_valid_o, 1'b1);
      check_rnd("rnd_ctr_o", rnd_ctr_o, round_count(g.key_len));
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    check_bit("out_valid_o", out_valid_o, 1'b1);
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
  endtask

  task automatic test_clears();
    cmd_t c;
    int   cyc;
    c                = '0;
    c.data_out_clear = 1'b1;
    send_cmd(c, cfg_i);
    check_bit("state_we", dp_ctrl_o.state_we, 1'b1);
    check_sel("state_sel", dp_ctrl_o.state_sel, STATE_CLEAR);
    wait_out_valid(1, cyc);
    check_cycle("data clear out_valid_o cycle", cyc, 2);
    check_bit("state_we", dp_ctrl_o.state_we, 1'b0);
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    c           = '0;
    c.key_clear = 1'b1;
    send_cmd(c, cfg_i);
    check_bit("out_valid_o", out_valid_o, 1'b1);
    check_bit("key_full_we", key_ctrl_o.key_full_we, 1'b1);
    check_bit("key_dec_we", key_ctrl_o.key_dec_we, 1'b1);
    check_full_sel("key_full_sel", key_ctrl_o.key_full_sel, KEY_FULL_CLEAR);
    check_dec_sel("key_dec_sel", key_ctrl_o.key_dec_sel, KEY_DEC_CLEAR);
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
  endtask

  task automatic test_errors();
    cmd_t c;
    cfg_t g;
    int   delay;
    // Handshake with no command bit
    send_cmd('0, cfg_i);
    check_bit("alert_o", alert_o, 1'b1);
    check_error_held(8);
    apply_reset();
    // Single fault bit in the middle of a block
    g.key_len = key_len_e'($unsigned($random(seed)) % 3);
    g.op      = ciph_op_e'($unsigned($random(seed)) % 2);
    delay     = 2 + $unsigned($random(seed)) % 16;
    c         = '0;
    c.crypt   = 1'b1;
    send_cmd(c, g);
    repeat (delay) @(posedge clk_i);
    err_i <= err_t'(5'b1 << ($unsigned($random(seed)) % 5));
    @(posedge clk_i);
    err_i <= '0;
    @(negedge clk_i);
    check_bit("alert_o", alert_o, 1'b1);
    check_error_held(8);
    apply_reset();
  endtask

  initial begin
    seed                 = 72109;
    rst_ni               = 1'b0;
    in_valid_i           = 1'b0;
    cmd_i                = '0;
    cfg_i                = '{op: CIPH_FWD, key_len: AES_128};
    out_ready_i          = 1'b1;
    key_expand_out_req_i = 1'b1;
    sub_bytes_out_req_i  = 1'b1;
    err_i                = '0;
    apply_reset();
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 3; j++) begin
        test_crypt(ciph_op_e'(i), key_len_e'(j));
      end
    end
    for (int j = 0; j < 3; j++) begin
      test_dec_key_gen(key_len_e'(j));
    end
    repeat (2) test_back_pressure();
    test_clears();
    test_errors();
    $display("No errors");
    $finish;
  end

endmodule
